// ==== verilog/decode_pkg.sv ====
package decode_pkg;

	////////////////////////////////////////////////////////////////////////////
	// field widths

	localparam int OPCODE_W   = 6;
	localparam int REG_ADDR_W = 5;
	localparam int INSN_W     = 32;
	localparam int DATA_W     = 32;
	localparam int ALU_OP2_W  = 4;
	localparam int COMP_OP_W  = 4;

	typedef logic [REG_ADDR_W-1:0] reg_addr_t;
	typedef logic [INSN_W-1:0]     insn_t;

	////////////////////////////////////////////////////////////////////////////
	// encodings

	// major opcode, insn[31:26]
	typedef enum logic [OPCODE_W-1:0] {
		OP_J      = 6'h00,
		OP_JAL    = 6'h01,
		OP_BNF    = 6'h03,
		OP_BF     = 6'h04,
		OP_NOP    = 6'h05,
		OP_MOVHI  = 6'h06,
		OP_XSYNC  = 6'h08,
		OP_RFE    = 6'h09,
		OP_JR     = 6'h11,
		OP_JALR   = 6'h12,
		OP_LWZ    = 6'h21,
		OP_LWS    = 6'h22,
		OP_LBZ    = 6'h23,
		OP_LBS    = 6'h24,
		OP_LHZ    = 6'h25,
		OP_LHS    = 6'h26,
		OP_ADDI   = 6'h27,
		OP_ADDIC  = 6'h28,
		OP_ANDI   = 6'h29,
		OP_ORI    = 6'h2a,
		OP_XORI   = 6'h2b,
		OP_MFSPR  = 6'h2d,
		OP_SFXXI  = 6'h2f,
		OP_MTSPR  = 6'h30,
		OP_SW     = 6'h35,
		OP_SB     = 6'h36,
		OP_SH     = 6'h37,
		OP_ALU    = 6'h38,
		OP_SFXX   = 6'h39
	} opcode_e;

	// mul/div codes exist only so that the decoder can reject them
	typedef enum logic [4:0] {
		ALU_ADD   = 5'h00,
		ALU_ADDC  = 5'h01,
		ALU_AND   = 5'h03,
		ALU_OR    = 5'h04,
		ALU_XOR   = 5'h05,
		ALU_MUL   = 5'h06,
		ALU_DIV   = 5'h09,
		ALU_DIVU  = 5'h0a,
		ALU_MULU  = 5'h0b,
		ALU_MOVHI = 5'h10,
		ALU_COMP  = 5'h11,
		ALU_NOP   = 5'h1f
	} alu_op_e;

	typedef enum logic [2:0] {
		BR_NOP = 3'd0,
		BR_J   = 3'd1,
		BR_JR  = 3'd2,
		BR_BF  = 3'd4,
		BR_BNF = 3'd5,
		BR_RFE = 3'd6
	} branch_op_e;

	typedef enum logic [3:0] {
		LSU_NOP = 4'b0000,
		LSU_LBZ = 4'b0010,
		LSU_LBS = 4'b0011,
		LSU_LHZ = 4'b0100,
		LSU_LHS = 4'b0101,
		LSU_LWZ = 4'b0110,
		LSU_LWS = 4'b0111,
		LSU_SB  = 4'b1010,
		LSU_SH  = 4'b1100,
		LSU_SW  = 4'b1110
	} lsu_op_e;

	typedef enum logic [2:0] {
		RFWB_NOP  = 3'd0,
		RFWB_ALU  = 3'd1,
		RFWB_LSU  = 3'd2,
		RFWB_SPRS = 3'd3,
		RFWB_LR   = 3'd4
	} rfwb_src_e;

	typedef struct packed {
		rfwb_src_e src;
		logic      we;
	} rfwb_op_t;

	typedef enum logic [1:0] {
		SEL_RF      = 2'd0,
		SEL_IMM     = 2'd1,
		SEL_EX_FORW = 2'd2,
		SEL_WB_FORW = 2'd3
	} sel_e;

	// void nop, bit 16 marks a bubble
	localparam insn_t     NOP_INSN = {OP_NOP, 26'h001_0000};
	localparam reg_addr_t LINK_REG = 5'd9;

	////////////////////////////////////////////////////////////////////////////
	// stage records

	typedef struct packed {
		insn_t      insn;
		branch_op_e branch_op;
		logic       sel_imm;
	} id_stage_t;

	typedef struct packed {
		alu_op_e              alu_op;
		logic [ALU_OP2_W-1:0] alu_op2;
		logic [COMP_OP_W-1:0] comp_op;
		rfwb_op_t             rfwb_op;
		reg_addr_t            rf_addrw;
		branch_op_e           branch_op;
		logic [DATA_W-1:0]    simm;
		logic                 spr_read;
		logic                 spr_write;
		logic                 except_illegal;
		logic                 sig_syscall;
		logic                 sig_trap;
	} ex_ctrl_t;

	typedef struct packed {
		reg_addr_t rf_addrw;
		logic      we;
	} wb_fwd_t;

	localparam id_stage_t ID_STAGE_NOP = '{
		insn: NOP_INSN,
		branch_op: BR_NOP,
		sel_imm: 1'b0
	};

	// what EX holds after reset, flush or a bubble
	localparam ex_ctrl_t EX_CTRL_NOP = '{
		alu_op: ALU_NOP,
		alu_op2: '0,
		comp_op: '0,
		rfwb_op: '{src: RFWB_NOP, we: 1'b0},
		rf_addrw: '0,
		branch_op: BR_NOP,
		simm: '0,
		spr_read: 1'b0,
		spr_write: 1'b0,
		except_illegal: 1'b0,
		sig_syscall: 1'b0,
		sig_trap: 1'b0
	};

endpackage

// ==== verilog/id_latch.sv ====
module id_latch import decode_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  insn_t     if_insn,
	input  logic      if_valid,
	input  logic      flush,
	output id_stage_t id_stage
);

	insn_t      next_insn;
	opcode_e    next_op;
	branch_op_e next_branch;
	logic       next_sel_imm;

	// no strobe or a flush puts a bubble into ID
	assign next_insn = (if_valid && !flush) ? if_insn : NOP_INSN;
	assign next_op   = opcode_e'(next_insn[31:26]);

	// branch predecode
	always_comb begin
		case (next_op)
			OP_J, OP_JAL:   next_branch = BR_J;
			OP_JR, OP_JALR: next_branch = BR_JR;
			OP_BF:          next_branch = BR_BF;
			OP_BNF:         next_branch = BR_BNF;
			OP_RFE:         next_branch = BR_RFE;
			default:        next_branch = BR_NOP;
		endcase
	end

	// operand b comes from the immediate unless the opcode has none
	always_comb begin
		case (next_op)
			OP_ALU, OP_SFXX,
			OP_JR, OP_JALR, OP_RFE,
			OP_MFSPR, OP_MTSPR, OP_XSYNC,
			OP_SW, OP_SB, OP_SH,
			OP_NOP:
				next_sel_imm = 1'b0;
			default:
				next_sel_imm = 1'b1;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			id_stage <= ID_STAGE_NOP;
		end else begin
			id_stage.insn      <= next_insn;
			id_stage.branch_op <= next_branch;
			id_stage.sel_imm   <= next_sel_imm;
		end
	end

endmodule

// ==== verilog/id_decode.sv ====
module id_decode import decode_pkg::*; (
	input  insn_t             if_insn,
	input  id_stage_t         id_stage,
	output reg_addr_t         rf_addra,
	output reg_addr_t         rf_addrb,
	output logic              rf_rda,
	output logic              rf_rdb,
	output lsu_op_e           id_lsu_op,
	output logic [DATA_W-1:0] simm
);

	opcode_e id_op;
	insn_t   insn;

	// register file is addressed straight from the fetched word
	assign rf_addra = if_insn[20:16];
	assign rf_addrb = if_insn[15:11];
	assign rf_rda   = if_insn[31];
	assign rf_rdb   = if_insn[30];

	assign insn  = id_stage.insn;
	assign id_op = opcode_e'(insn[31:26]);

	// immediate extension
	always_comb begin
		case (id_op)
			OP_ADDI, OP_ADDIC, OP_XORI, OP_SFXXI,
			OP_LWZ, OP_LWS, OP_LBZ, OP_LBS, OP_LHZ, OP_LHS:
				simm = {{16{insn[15]}}, insn[15:0]};
			// store offset is split around the rB field
			OP_SW, OP_SB, OP_SH:
				simm = {{16{insn[25]}}, insn[25:21], insn[10:0]};
			OP_MTSPR:
				simm = {16'b0, insn[25:21], insn[10:0]};
			default:
				simm = {16'b0, insn[15:0]};
		endcase
	end

	// load/store op
	always_comb begin
		case (id_op)
			OP_LWZ:  id_lsu_op = LSU_LWZ;
			OP_LWS:  id_lsu_op = LSU_LWS;
			OP_LBZ:  id_lsu_op = LSU_LBZ;
			OP_LBS:  id_lsu_op = LSU_LBS;
			OP_LHZ:  id_lsu_op = LSU_LHZ;
			OP_LHS:  id_lsu_op = LSU_LHS;
			OP_SW:   id_lsu_op = LSU_SW;
			OP_SB:   id_lsu_op = LSU_SB;
			OP_SH:   id_lsu_op = LSU_SH;
			default: id_lsu_op = LSU_NOP;
		endcase
	end

endmodule

// ==== verilog/ex_decode.sv ====
module ex_decode import decode_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              flush,
	input  id_stage_t         id_stage,
	input  logic [DATA_W-1:0] simm,
	output ex_ctrl_t          ex_ctrl,
	output insn_t             ex_insn
);

	insn_t      insn;
	opcode_e    op;
	logic [4:0] sub_op;
	ex_ctrl_t   next_ctrl;

	assign insn   = id_stage.insn;
	assign op     = opcode_e'(insn[31:26]);
	assign sub_op = insn[4:0];

	////////////////////////////////////////////////////////////////////////////
	// EX control decode from the ID word

	always_comb begin
		next_ctrl = EX_CTRL_NOP;

		// raw fields, meaningful only for the ops that use them
		next_ctrl.alu_op2   = insn[9:6];
		next_ctrl.comp_op   = insn[24:21];
		next_ctrl.branch_op = id_stage.branch_op;
		next_ctrl.simm      = simm;

		// jump and link writes r9
		if (op == OP_JAL || op == OP_JALR)
			next_ctrl.rf_addrw = LINK_REG;
		else
			next_ctrl.rf_addrw = insn[25:21];

		// alu op and write-back source
		case (op)
			OP_JAL, OP_JALR: begin
				next_ctrl.rfwb_op = '{src: RFWB_LR, we: 1'b1};
			end
			OP_MFSPR: begin
				next_ctrl.rfwb_op  = '{src: RFWB_SPRS, we: 1'b1};
				next_ctrl.spr_read = 1'b1;
			end
			OP_MTSPR: begin
				next_ctrl.spr_write = 1'b1;
			end
			OP_LWZ, OP_LWS, OP_LBZ, OP_LBS, OP_LHZ, OP_LHS: begin
				next_ctrl.rfwb_op = '{src: RFWB_LSU, we: 1'b1};
			end
			OP_MOVHI: begin
				next_ctrl.alu_op  = ALU_MOVHI;
				next_ctrl.rfwb_op = '{src: RFWB_ALU, we: 1'b1};
			end
			OP_ADDI: begin
				next_ctrl.alu_op  = ALU_ADD;
				next_ctrl.rfwb_op = '{src: RFWB_ALU, we: 1'b1};
			end
			OP_ADDIC: begin
				next_ctrl.alu_op  = ALU_ADDC;
				next_ctrl.rfwb_op = '{src: RFWB_ALU, we: 1'b1};
			end
			OP_ANDI: begin
				next_ctrl.alu_op  = ALU_AND;
				next_ctrl.rfwb_op = '{src: RFWB_ALU, we: 1'b1};
			end
			OP_ORI: begin
				next_ctrl.alu_op  = ALU_OR;
				next_ctrl.rfwb_op = '{src: RFWB_ALU, we: 1'b1};
			end
			OP_XORI: begin
				next_ctrl.alu_op  = ALU_XOR;
				next_ctrl.rfwb_op = '{src: RFWB_ALU, we: 1'b1};
			end
			// register form takes the low sub-op field
			OP_ALU: begin
				next_ctrl.alu_op  = alu_op_e'({1'b0, insn[3:0]});
				next_ctrl.rfwb_op = '{src: RFWB_ALU, we: 1'b1};
			end
			// compares only set the flag
			OP_SFXX, OP_SFXXI: begin
				next_ctrl.alu_op = ALU_COMP;
			end
			default: begin
			end
		endcase

		// illegal opcodes, plus mul/div since there is no multiplier
		case (op)
			OP_J, OP_JAL, OP_JALR, OP_JR, OP_BNF, OP_BF, OP_RFE,
			OP_MOVHI, OP_MFSPR, OP_MTSPR, OP_XSYNC, OP_NOP,
			OP_LWZ, OP_LWS, OP_LBZ, OP_LBS, OP_LHZ, OP_LHS,
			OP_ADDI, OP_ADDIC, OP_ANDI, OP_ORI, OP_XORI,
			OP_SFXXI, OP_SW, OP_SB, OP_SH, OP_SFXX:
				next_ctrl.except_illegal = 1'b0;
			OP_ALU:
				next_ctrl.except_illegal = (sub_op == ALU_MUL) || (sub_op == ALU_MULU) ||
					(sub_op == ALU_DIV) || (sub_op == ALU_DIVU);
			default:
				next_ctrl.except_illegal = 1'b1;
		endcase

		// l.sys and l.trap
		next_ctrl.sig_syscall = (insn[31:23] == {OP_XSYNC, 3'b000});
		next_ctrl.sig_trap    = (insn[31:23] == {OP_XSYNC, 3'b010});
	end

	////////////////////////////////////////////////////////////////////////////
	// EX registers

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_ctrl <= EX_CTRL_NOP;
			ex_insn <= NOP_INSN;
		end else if (flush) begin
			ex_ctrl <= EX_CTRL_NOP;
			ex_insn <= NOP_INSN;
		end else begin
			ex_ctrl <= next_ctrl;
			ex_insn <= insn;
		end
	end

endmodule

// ==== verilog/operand_forward.sv ====
module operand_forward import decode_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  id_stage_t id_stage,
	input  ex_ctrl_t  ex_ctrl,
	input  insn_t     ex_insn,
	output sel_e      sel_a,
	output sel_e      sel_b,
	output insn_t     wb_insn
);

	wb_fwd_t wb_fwd;

	// EX result wins over WB, register file last
	function automatic sel_e fwd_sel(reg_addr_t src, ex_ctrl_t ex, wb_fwd_t wb);
		if (src == ex.rf_addrw && ex.rfwb_op.we)
			return SEL_EX_FORW;
		else if (src == wb.rf_addrw && wb.we)
			return SEL_WB_FORW;
		else
			return SEL_RF;
	endfunction

	// WB stage, keeps the old EX insn through a flush
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_fwd  <= '0;
			wb_insn <= NOP_INSN;
		end else begin
			wb_fwd.rf_addrw <= ex_ctrl.rf_addrw;
			wb_fwd.we       <= ex_ctrl.rfwb_op.we;
			wb_insn         <= ex_insn;
		end
	end

	assign sel_a = fwd_sel(id_stage.insn[20:16], ex_ctrl, wb_fwd);

	// immediate takes operand b
	assign sel_b = id_stage.sel_imm ? SEL_IMM :
		fwd_sel(id_stage.insn[15:11], ex_ctrl, wb_fwd);

endmodule

// ==== verilog/decode_ctrl.sv ====
module decode_ctrl import decode_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  insn_t      if_insn,
	input  logic       if_valid,
	input  logic       flush,
	output reg_addr_t  rf_addra,
	output reg_addr_t  rf_addrb,
	output logic       rf_rda,
	output logic       rf_rdb,
	output branch_op_e id_branch_op,
	output lsu_op_e    id_lsu_op,
	output sel_e       sel_a,
	output sel_e       sel_b,
	output ex_ctrl_t   ex_ctrl,
	output insn_t      ex_insn,
	output insn_t      wb_insn
);

	id_stage_t         id_stage;
	logic [DATA_W-1:0] simm;

	assign id_branch_op = id_stage.branch_op;

	// IF to ID
	id_latch i_id_latch (
		.clk      (clk),
		.rst_n    (rst_n),
		.if_insn  (if_insn),
		.if_valid (if_valid),
		.flush    (flush),
		.id_stage (id_stage)
	);

	id_decode i_id_decode (
		.if_insn   (if_insn),
		.id_stage  (id_stage),
		.rf_addra  (rf_addra),
		.rf_addrb  (rf_addrb),
		.rf_rda    (rf_rda),
		.rf_rdb    (rf_rdb),
		.id_lsu_op (id_lsu_op),
		.simm      (simm)
	);

	// ID to EX
	ex_decode i_ex_decode (
		.clk      (clk),
		.rst_n    (rst_n),
		.flush    (flush),
		.id_stage (id_stage),
		.simm     (simm),
		.ex_ctrl  (ex_ctrl),
		.ex_insn  (ex_insn)
	);

	// EX to WB and the operand selects
	operand_forward i_operand_forward (
		.clk      (clk),
		.rst_n    (rst_n),
		.id_stage (id_stage),
		.ex_ctrl  (ex_ctrl),
		.ex_insn  (ex_insn),
		.sel_a    (sel_a),
		.sel_b    (sel_b),
		.wb_insn  (wb_insn)
	);

endmodule

// ==== bench/decode_ctrl_checker.sv ====
module decode_ctrl_checker import decode_pkg::*; (
	input logic      clk,
	input logic      rst_n,
	input logic      flush,
	input id_stage_t id_stage,
	input ex_ctrl_t  ex_ctrl,
	input insn_t     ex_insn
);

	timeunit 1ns;
	timeprecision 1ps;

	// a flushed slot leaves nothing active in EX
	flush_clears_ex: assert property (@(posedge clk) disable iff (!rst_n)
		flush |=> ex_ctrl == EX_CTRL_NOP)
	else $error("EX controls still active the cycle after a flush");

	// ID takes the bubble word on flush
	flush_clears_id: assert property (@(posedge clk) disable iff (!rst_n)
		flush |=> id_stage.insn == NOP_INSN)
	else $error("ID does not hold the NOP bubble after a flush");

	// syscall and trap only with an XSYNC word in EX, never both
	sys_trap_from_xsync: assert property (@(posedge clk) disable iff (!rst_n)
		(ex_ctrl.sig_syscall || ex_ctrl.sig_trap) |->
			(ex_insn[31:26] == OP_XSYNC) && !(ex_ctrl.sig_syscall && ex_ctrl.sig_trap))
	else $error("syscall or trap raised without an XSYNC in EX, or both together");

endmodule

// id_stage here is the ID latch output feeding EX
bind ex_decode decode_ctrl_checker i_decode_ctrl_checker (
	.clk      (clk),
	.rst_n    (rst_n),
	.flush    (flush),
	.id_stage (id_stage),
	.ex_ctrl  (ex_ctrl),
	.ex_insn  (ex_insn)
);

// ==== bench/decode_ctrl_tb.sv ====
module decode_ctrl_tb import decode_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int          CLK_PERIOD  = 40;
	localparam int          NUM_CYCLES  = 600;
	localparam int          DRAIN_LIMIT = 8;
	localparam int unsigned RAND_SEED   = 32'hbbe0e171;

	localparam logic [5:0] LEGAL_OPS [29] = '{
		OP_J, OP_JAL, OP_JALR, OP_JR, OP_BNF, OP_BF, OP_RFE, OP_MOVHI, OP_MFSPR,
		OP_MTSPR, OP_XSYNC, OP_NOP, OP_LWZ, OP_LWS, OP_LBZ, OP_LBS, OP_LHZ, OP_LHS,
		OP_ADDI, OP_ADDIC, OP_ANDI, OP_ORI, OP_XORI, OP_SFXXI, OP_SW, OP_SB, OP_SH,
		OP_ALU, OP_SFXX
	};
	localparam logic [5:0] ILLEGAL_OPS [8] = '{
		6'h02, 6'h07, 6'h0a, 6'h13, 6'h20, 6'h2c, 6'h2e, 6'h3f
	};
	localparam logic [4:0] MULDIV_OPS [4] = '{ALU_MUL, ALU_MULU, ALU_DIV, ALU_DIVU};
	// few registers so forwarding hits often
	localparam reg_addr_t  HOT_REGS [4] = '{5'd1, 5'd2, 5'd3, LINK_REG};

	logic       clk;
	logic       rst_n;
	insn_t      if_insn;
	logic       if_valid;
	logic       flush;
	reg_addr_t  rf_addra;
	reg_addr_t  rf_addrb;
	logic       rf_rda;
	logic       rf_rdb;
	branch_op_e id_branch_op;
	lsu_op_e    id_lsu_op;
	sel_e       sel_a;
	sel_e       sel_b;
	ex_ctrl_t   ex_ctrl;
	insn_t      ex_insn;
	insn_t      wb_insn;

	// shadow pipeline, [0] ID, [1] EX, [2] WB
	insn_t shadow [$] = '{NOP_INSN, NOP_INSN, NOP_INSN};
	int    errors       = 0;
	int    checks       = 0;
	int    fwd_hits     = 0;
	int    illegal_hits = 0;

	decode_ctrl i_decode_ctrl (
		.clk          (clk),
		.rst_n        (rst_n),
		.if_insn      (if_insn),
		.if_valid     (if_valid),
		.flush        (flush),
		.rf_addra     (rf_addra),
		.rf_addrb     (rf_addrb),
		.rf_rda       (rf_rda),
		.rf_rdb       (rf_rdb),
		.id_branch_op (id_branch_op),
		.id_lsu_op    (id_lsu_op),
		.sel_a        (sel_a),
		.sel_b        (sel_b),
		.ex_ctrl      (ex_ctrl),
		.ex_insn      (ex_insn),
		.wb_insn      (wb_insn)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// reference model

	function automatic branch_op_e ref_branch(logic [5:0] op);
		case (op)
			OP_J, OP_JAL:   return BR_J;
			OP_JR, OP_JALR: return BR_JR;
			OP_BF:          return BR_BF;
			OP_BNF:         return BR_BNF;
			OP_RFE:         return BR_RFE;
			default:        return BR_NOP;
		endcase
	endfunction

	function automatic lsu_op_e ref_lsu(logic [5:0] op);
		case (op)
			OP_LWZ:  return LSU_LWZ;
			OP_LWS:  return LSU_LWS;
			OP_LBZ:  return LSU_LBZ;
			OP_LBS:  return LSU_LBS;
			OP_LHZ:  return LSU_LHZ;
			OP_LHS:  return LSU_LHS;
			OP_SW:   return LSU_SW;
			OP_SB:   return LSU_SB;
			OP_SH:   return LSU_SH;
			default: return LSU_NOP;
		endcase
	endfunction

	function automatic logic [31:0] ref_simm(insn_t w);
		logic [5:0] op;
		op = w[31:26];
		if (op inside {OP_ADDI, OP_ADDIC, OP_XORI, OP_SFXXI,
				OP_LWZ, OP_LWS, OP_LBZ, OP_LBS, OP_LHZ, OP_LHS})
			return 32'($signed(w[15:0]));
		if (op inside {OP_SW, OP_SB, OP_SH})
			return 32'($signed({w[25:21], w[10:0]}));
		if (op == OP_MTSPR)
			return {16'h0, w[25:21], w[10:0]};
		return {16'h0, w[15:0]};
	endfunction

	function automatic bit takes_imm(logic [5:0] op);
		return !(op inside {OP_ALU, OP_SFXX, OP_JR, OP_JALR, OP_RFE, OP_MFSPR,
			OP_MTSPR, OP_XSYNC, OP_SW, OP_SB, OP_SH, OP_NOP});
	endfunction

	function automatic ex_ctrl_t ref_ctrl(insn_t w);
		ex_ctrl_t   c;
		logic [5:0] op;
		op = w[31:26];
		c.alu_op         = ALU_NOP;
		c.alu_op2        = w[9:6];
		c.comp_op        = w[24:21];
		c.rfwb_op        = '{RFWB_NOP, 1'b0};
		c.rf_addrw       = (op inside {OP_JAL, OP_JALR}) ? LINK_REG : w[25:21];
		c.branch_op      = ref_branch(op);
		c.simm           = ref_simm(w);
		c.spr_read       = (op == OP_MFSPR);
		c.spr_write      = (op == OP_MTSPR);
		c.sig_syscall    = (op == OP_XSYNC) && (w[25:23] == 3'b000);
		c.sig_trap       = (op == OP_XSYNC) && (w[25:23] == 3'b010);
		c.except_illegal = !(op inside {OP_J, OP_JAL, OP_JALR, OP_JR, OP_BNF, OP_BF,
			OP_RFE, OP_MOVHI, OP_MFSPR, OP_MTSPR, OP_XSYNC, OP_NOP, OP_LWZ, OP_LWS,
			OP_LBZ, OP_LBS, OP_LHZ, OP_LHS, OP_ADDI, OP_ADDIC, OP_ANDI, OP_ORI,
			OP_XORI, OP_SFXXI, OP_SW, OP_SB, OP_SH, OP_ALU, OP_SFXX}) ||
			(op == OP_ALU && w[4:0] inside {ALU_MUL, ALU_MULU, ALU_DIV, ALU_DIVU});
		case (op)
			OP_JAL, OP_JALR: c.rfwb_op = '{RFWB_LR, 1'b1};
			OP_MFSPR:        c.rfwb_op = '{RFWB_SPRS, 1'b1};
			OP_LWZ, OP_LWS, OP_LBZ, OP_LBS, OP_LHZ, OP_LHS:
				c.rfwb_op = '{RFWB_LSU, 1'b1};
			OP_SFXX, OP_SFXXI: c.alu_op = ALU_COMP;
			OP_MOVHI:          c.alu_op = ALU_MOVHI;
			OP_ADDI:           c.alu_op = ALU_ADD;
			OP_ADDIC:          c.alu_op = ALU_ADDC;
			OP_ANDI:           c.alu_op = ALU_AND;
			OP_ORI:            c.alu_op = ALU_OR;
			OP_XORI:           c.alu_op = ALU_XOR;
			OP_ALU:            c.alu_op = alu_op_e'({1'b0, w[3:0]});
			default: ;
		endcase
		// every real alu op except compare writes its result back
		if (c.alu_op != ALU_NOP && c.alu_op != ALU_COMP)
			c.rfwb_op = '{RFWB_ALU, 1'b1};
		return c;
	endfunction

	function automatic sel_e ref_sel(reg_addr_t src, insn_t ex_w, insn_t wb_w);
		ex_ctrl_t ex_c;
		ex_ctrl_t wb_c;
		ex_c = ref_ctrl(ex_w);
		wb_c = ref_ctrl(wb_w);
		if (ex_c.rfwb_op.we && ex_c.rf_addrw == src)
			return SEL_EX_FORW;
		if (wb_c.rfwb_op.we && wb_c.rf_addrw == src)
			return SEL_WB_FORW;
		return SEL_RF;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// stimulus helpers

	function automatic reg_addr_t pick_reg();
		if ($urandom % 4 != 0)
			return HOT_REGS[2'($urandom)];
		return 5'($urandom);
	endfunction

	function automatic insn_t random_insn();
		insn_t w;
		w = $urandom;
		if ($urandom % 8 == 0)
			w[31:26] = ILLEGAL_OPS[3'($urandom)];
		else
			w[31:26] = LEGAL_OPS[5'($urandom % 29)];
		w[25:21] = pick_reg();
		w[20:16] = pick_reg();
		w[15:11] = pick_reg();
		if (w[31:26] == OP_ALU && $urandom % 3 == 0)
			w[4:0] = MULDIV_OPS[2'($urandom)];
		return w;
	endfunction

	task automatic flag_mismatch(string msg);
		$display("** Error at %0d ns: %s", $time, msg);
		errors++;
	endtask

	task automatic check_outputs();
		ex_ctrl_t   want;
		sel_e       want_a;
		sel_e       want_b;
		insn_t      id_w;
		logic [5:0] id_op;
		id_w   = shadow[0];
		id_op  = id_w[31:26];
		want   = ref_ctrl(shadow[1]);
		want_a = ref_sel(id_w[20:16], shadow[1], shadow[2]);
		want_b = takes_imm(id_op) ? SEL_IMM : ref_sel(id_w[15:11], shadow[1], shadow[2]);
		checks++;
		if (want_a inside {SEL_EX_FORW, SEL_WB_FORW})
			fwd_hits++;
		if (want.except_illegal)
			illegal_hits++;
		if (ex_ctrl.alu_op !== want.alu_op || ex_ctrl.alu_op2 !== want.alu_op2 ||
				ex_ctrl.comp_op !== want.comp_op)
			flag_mismatch($sformatf("insn %h alu %h/%h/%h, expected %h/%h/%h", shadow[1],
				ex_ctrl.alu_op, ex_ctrl.alu_op2, ex_ctrl.comp_op,
				want.alu_op, want.alu_op2, want.comp_op));
		if (ex_ctrl.rfwb_op !== want.rfwb_op || ex_ctrl.rf_addrw !== want.rf_addrw)
			flag_mismatch($sformatf("insn %h rfwb %h rd %0d, expected %h rd %0d", shadow[1],
				ex_ctrl.rfwb_op, ex_ctrl.rf_addrw, want.rfwb_op, want.rf_addrw));
		if (ex_ctrl.simm !== want.simm)
			flag_mismatch($sformatf("insn %h simm %h, expected %h", shadow[1],
				ex_ctrl.simm, want.simm));
		if (ex_ctrl.spr_read !== want.spr_read || ex_ctrl.spr_write !== want.spr_write)
			flag_mismatch($sformatf("insn %h spr bits wrong", shadow[1]));
		if (ex_ctrl.except_illegal !== want.except_illegal)
			flag_mismatch($sformatf("insn %h illegal %b, expected %b", shadow[1],
				ex_ctrl.except_illegal, want.except_illegal));
		if (ex_ctrl.sig_syscall !== want.sig_syscall || ex_ctrl.sig_trap !== want.sig_trap)
			flag_mismatch($sformatf("insn %h syscall/trap %b%b, expected %b%b", shadow[1],
				ex_ctrl.sig_syscall, ex_ctrl.sig_trap, want.sig_syscall, want.sig_trap));
		if (ex_ctrl.branch_op !== want.branch_op || id_branch_op !== ref_branch(id_op))
			flag_mismatch($sformatf("branch op ex %h id %h wrong", ex_ctrl.branch_op,
				id_branch_op));
		if (ex_insn !== shadow[1] || wb_insn !== shadow[2])
			flag_mismatch($sformatf("ex/wb insn %h/%h, expected %h/%h", ex_insn, wb_insn,
				shadow[1], shadow[2]));
		if (sel_a !== want_a || sel_b !== want_b)
			flag_mismatch($sformatf("id insn %h sel %h/%h, expected %h/%h", id_w,
				sel_a, sel_b, want_a, want_b));
		if (id_lsu_op !== ref_lsu(id_op))
			flag_mismatch($sformatf("id insn %h lsu op %h", id_w, id_lsu_op));
		if (rf_addra !== if_insn[20:16] || rf_addrb !== if_insn[15:11])
			flag_mismatch($sformatf("read addresses %0d/%0d for %h", rf_addra, rf_addrb,
				if_insn));
		// read enables follow the two top opcode bits
		if (rf_rda !== if_insn[31] || rf_rdb !== if_insn[30])
			flag_mismatch($sformatf("read enables %b/%b for %h", rf_rda, rf_rdb, if_insn));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// comparator, steps the shadow pipe on each edge

	initial begin : compare
		insn_t next_id;
		insn_t next_ex;
		forever begin
			@(posedge clk);
			if (rst_n) begin
				next_id = (if_valid && !flush) ? if_insn : NOP_INSN;
				next_ex = flush ? NOP_INSN : shadow[0];
				shadow  = '{next_id, next_ex, shadow[1]};
			end
			// outputs settled, inputs not yet changed
			#(CLK_PERIOD / 4);
			if (rst_n)
				check_outputs();
		end
	end

	initial begin : stimulus
		int unsigned seed_ret;
		int          guard;
		seed_ret = $urandom(RAND_SEED);
		rst_n    = 1'b0;
		if_insn  = NOP_INSN;
		if_valid = 1'b0;
		flush    = 1'b0;
		repeat (3) @(negedge clk);
		rst_n = 1'b1;

		// idle after reset
		repeat (3) @(negedge clk);
		if (ex_ctrl !== EX_CTRL_NOP)
			flag_mismatch($sformatf("ex_ctrl %h after reset, expected inactive", ex_ctrl));
		if (wb_insn !== NOP_INSN)
			flag_mismatch($sformatf("wb_insn %h after reset, expected %h", wb_insn, NOP_INSN));

		repeat (NUM_CYCLES) begin
			if_insn  = random_insn();
			if_valid = ($urandom % 6) != 0;
			flush    = ($urandom % 12) == 0;
			@(negedge clk);
		end

		// drain with bubbles
		if_valid = 1'b0;
		flush    = 1'b0;
		@(negedge clk);
		guard = 0;
		while ((ex_insn !== NOP_INSN || wb_insn !== NOP_INSN) && guard < DRAIN_LIMIT) begin
			@(negedge clk);
			guard++;
		end
		if (ex_insn !== NOP_INSN || wb_insn !== NOP_INSN) begin
			$display("timeout: pipeline not drained after %0d bubble cycles", DRAIN_LIMIT);
			$display(">>> FAIL");
			$finish;
		end else begin
			$display("checks %0d, errors %0d, forwards %0d, illegal %0d",
				checks, errors, fwd_hits, illegal_hits);
			if (errors == 0 && checks > 0)
				$display(">>> PASS");
			else
				$display(">>> FAIL");
			$finish;
		end
	end

endmodule

// ==== sim.f ====
verilog/decode_pkg.sv
verilog/id_latch.sv
verilog/id_decode.sv
verilog/ex_decode.sv
verilog/operand_forward.sv
verilog/decode_ctrl.sv
bench/decode_ctrl_checker.sv
bench/decode_ctrl_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the decode controller testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module decode_ctrl_tb \
	-f sim.f -Mdir obj_dir -o decode_ctrl_sim > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }
./obj_dir/decode_ctrl_sim > sim.log 2>&1
cat sim.log
grep -qx '>>> PASS' sim.log && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
